/* hw/vga_defines.svh */
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// Horizontal raster timing in pixel clocks.
`define VGA_H_VISIBLE 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_TOTAL 800

// Vertical raster timing in lines.
`define VGA_V_VISIBLE 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_TOTAL 525

// Pixel and counter widths.
`define VGA_PIXEL_WIDTH 8
`define VGA_COORD_WIDTH 11

// Host bus widths.
`define BUS_WIDTH 32
`define CTRL_WIDTH 8

// Control field layout.
`define CTRL_WRITE_BIT 1
`define CTRL_REG_LSB 4
`define CTRL_REG_WIDTH 4

`endif

/* hw/bus_pkg.sv */
`include "vga_defines.svh"
`default_nettype none

package bus_pkg;

	typedef logic [`BUS_WIDTH-1:0] bus_word_t; // Data word or word address.
	typedef logic [`CTRL_WIDTH-1:0] ctrl_t;
	typedef logic [`CTRL_REG_WIDTH-1:0] reg_idx_t;

	// Slave register map.
	localparam reg_idx_t reg_base = reg_idx_t'(0);
	localparam reg_idx_t reg_enable = reg_idx_t'(1);

	function automatic logic ctrl_is_write(ctrl_t ctrl);
		return ctrl[`CTRL_WRITE_BIT];
	endfunction

	function automatic reg_idx_t ctrl_reg(ctrl_t ctrl);
		return ctrl[`CTRL_REG_LSB +: `CTRL_REG_WIDTH];
	endfunction

endpackage

`default_nettype wire

/* hw/vga_pkg.sv */
`include "vga_defines.svh"
`default_nettype none

package vga_pkg;

	typedef logic [`VGA_PIXEL_WIDTH-1:0] pixel_t;

	// One fetched word. The low byte is the even pixel.
	typedef logic [2*`VGA_PIXEL_WIDTH-1:0] pixel_pair_t;

	typedef logic [`VGA_COORD_WIDTH-1:0] coord_t; // Row or column count.

	typedef enum logic {
		fetch_idle,
		fetch_wait
	} fetch_state_t;

endpackage

`default_nettype wire

/* hw/vga_sync_gen.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"
`default_nettype none

module vga_sync_gen (
	input wire logic clk25mhz,
	input wire logic rst,
	output vga_pkg::coord_t row,
	output vga_pkg::coord_t col,
	output logic visible,
	output logic hsync_n,
	output logic vsync_n,
	output logic frame_start
);

	localparam vga_pkg::coord_t h_last = vga_pkg::coord_t'(`VGA_H_TOTAL - 1);
	localparam vga_pkg::coord_t v_last = vga_pkg::coord_t'(`VGA_V_TOTAL - 1);
	localparam vga_pkg::coord_t h_vis = vga_pkg::coord_t'(`VGA_H_VISIBLE);
	localparam vga_pkg::coord_t v_vis = vga_pkg::coord_t'(`VGA_V_VISIBLE);
	localparam vga_pkg::coord_t h_sync_start =
		vga_pkg::coord_t'(`VGA_H_VISIBLE + `VGA_H_FRONT);
	localparam vga_pkg::coord_t h_sync_end =
		vga_pkg::coord_t'(`VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC);
	localparam vga_pkg::coord_t v_sync_start =
		vga_pkg::coord_t'(`VGA_V_VISIBLE + `VGA_V_FRONT);
	localparam vga_pkg::coord_t v_sync_end =
		vga_pkg::coord_t'(`VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC);

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			col <= '0;
			row <= '0;
		end else if (col == h_last) begin
			col <= '0;
			if (row == v_last)
				row <= '0;
			else
				row <= row + 1'b1;
		end else begin
			col <= col + 1'b1;
		end
	end

	assign visible = (col < h_vis) && (row < v_vis);

	// Sync pulses are active low.
	assign hsync_n = !((col >= h_sync_start) && (col < h_sync_end));
	assign vsync_n = !((row >= v_sync_start) && (row < v_sync_end));

	assign frame_start = (col == h_last) && (row == v_last); // Last pixel of the frame.

endmodule

`default_nettype wire

/* hw/vga_slave_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_slave_regs (
	input wire logic clk25mhz,
	input wire logic rst,
	input wire logic bus_slave_en,
	input wire bus_pkg::ctrl_t ctrl_in,
	input wire bus_pkg::bus_word_t bus_in,
	output bus_pkg::bus_word_t base_addr,
	output logic enable_req
);

	logic wr;

	assign wr = bus_slave_en && bus_pkg::ctrl_is_write(ctrl_in);

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			base_addr <= '0;
			enable_req <= 1'b0;
		end else if (wr) begin
			case (bus_pkg::ctrl_reg(ctrl_in))
				bus_pkg::reg_base: base_addr <= bus_in; // Word address of row 0.
				bus_pkg::reg_enable: enable_req <= bus_in[0];
				default: ; // Unmapped index.
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/vga_fetch_master.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"
`default_nettype none

module vga_fetch_master (
	input wire logic clk25mhz,
	input wire logic rst,
	input wire vga_pkg::coord_t row,
	input wire vga_pkg::coord_t col,
	input wire logic visible,
	input wire logic frame_start,
	input wire bus_pkg::bus_word_t base_addr,
	input wire logic enable_req,
	input wire logic bus_master_ack,
	output logic bus_req,
	output bus_pkg::bus_word_t bus_out,
	output logic buf0_we,
	output logic buf1_we,
	output logic display_on
);

	// Decisions are made one column early so that bus_req is high at the fetch column.
	localparam vga_pkg::coord_t pair0_col = vga_pkg::coord_t'(`VGA_H_TOTAL - 5);
	localparam vga_pkg::coord_t pair1_col = vga_pkg::coord_t'(`VGA_H_TOTAL - 1);
	localparam vga_pkg::coord_t pairn_end = vga_pkg::coord_t'(`VGA_H_VISIBLE - 4);
	localparam vga_pkg::coord_t row_last_vis = vga_pkg::coord_t'(`VGA_V_VISIBLE - 1);
	localparam vga_pkg::coord_t row_last = vga_pkg::coord_t'(`VGA_V_TOTAL - 1);

	vga_pkg::fetch_state_t state;
	bus_pkg::bus_word_t word_addr; // Address of the next pair to fetch.
	bus_pkg::bus_word_t issue_addr;
	logic on_pend;
	logic req_odd;
	logic next_row_vis;
	logic pair0_go;
	logic pair1_go;
	logic pairn_go;
	logic frame_first;
	logic issue_on;
	logic pair_odd;
	logic issue;

	assign next_row_vis = (row < row_last_vis) || (row == row_last);

	assign pair0_go = (col == pair0_col) && next_row_vis;
	assign pair1_go = (col == pair1_col) && next_row_vis;
	assign pairn_go = visible && col[0] && (col < pairn_end);
	assign frame_first = pair0_go && (row == row_last);

	// The first two fetches of a frame run ahead of frame_start.
	always_comb begin
		if (frame_first)
			issue_on = enable_req;
		else if (frame_start)
			issue_on = on_pend;
		else
			issue_on = display_on;
	end

	assign pair_odd = col[1] && !pair0_go; // Buffer of the pair being requested.
	assign issue = (pair0_go || pair1_go || pairn_go) && issue_on &&
		((state == vga_pkg::fetch_idle) || bus_master_ack);
	assign issue_addr = frame_first ? base_addr : word_addr;

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			state <= vga_pkg::fetch_idle;
			on_pend <= 1'b0;
			display_on <= 1'b0;
		end else begin
			if (issue)
				state <= vga_pkg::fetch_wait;
			else if ((state == vga_pkg::fetch_wait) && bus_master_ack)
				state <= vga_pkg::fetch_idle;
			if (frame_first)
				on_pend <= enable_req;
			if (frame_start)
				display_on <= on_pend;
		end
	end

	always_ff @(posedge clk25mhz) begin
		if (issue) begin
			bus_out <= issue_addr;
			word_addr <= issue_addr + 1'b1;
			req_odd <= pair_odd;
		end
	end

	assign bus_req = (state == vga_pkg::fetch_wait);

	assign buf0_we = bus_req && bus_master_ack && !req_odd;
	assign buf1_we = bus_req && bus_master_ack && req_odd;

endmodule

`default_nettype wire

/* hw/vga_pixel_pipe.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"
`default_nettype none

module vga_pixel_pipe (
	input wire logic clk25mhz,
	input wire logic rst,
	input wire vga_pkg::pixel_pair_t bus_in,
	input wire logic buf0_we,
	input wire logic buf1_we,
	input wire vga_pkg::coord_t col,
	input wire logic visible,
	input wire logic display_on,
	input wire logic hsync_n,
	input wire logic vsync_n,
	output vga_pkg::pixel_t rgb,
	output logic hsync,
	output logic vsync
);

	vga_pkg::pixel_pair_t buf0;
	vga_pkg::pixel_pair_t buf1;
	vga_pkg::pixel_pair_t pair;
	vga_pkg::pixel_t pixel;

	always_ff @(posedge clk25mhz) begin
		if (buf0_we)
			buf0 <= bus_in;
		if (buf1_we)
			buf1 <= bus_in;
	end

	// Pair q lives in buffer q mod 2 and is shown at columns 2q and 2q+1.
	assign pair = col[1] ? buf1 : buf0;
	assign pixel = col[0] ? pair[`VGA_PIXEL_WIDTH +: `VGA_PIXEL_WIDTH]
		: pair[0 +: `VGA_PIXEL_WIDTH];

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			rgb <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			rgb <= (visible && display_on) ? pixel : '0; // Blank outside the picture.
			hsync <= hsync_n;
			vsync <= vsync_n;
		end
	end

endmodule

`default_nettype wire

/* hw/vga_display.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"
`default_nettype none

module vga_display (
	input wire logic clk25mhz,
	input wire logic rst,
	input wire logic bus_master_ack,
	input wire logic bus_slave_en,
	input wire bus_pkg::bus_word_t bus_in,
	input wire bus_pkg::ctrl_t ctrl_in,
	output logic bus_req,
	output bus_pkg::bus_word_t bus_out,
	output vga_pkg::pixel_t rgb,
	output logic hsync,
	output logic vsync
);

	vga_pkg::coord_t row;
	vga_pkg::coord_t col;
	logic visible;
	logic hsync_n;
	logic vsync_n;
	logic frame_start;
	bus_pkg::bus_word_t base_addr;
	logic enable_req;
	logic buf0_we;
	logic buf1_we;
	logic display_on;

	vga_sync_gen u_sync (
		.clk25mhz(clk25mhz),
		.rst(rst),
		.row(row),
		.col(col),
		.visible(visible),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.frame_start(frame_start)
	);

	vga_slave_regs u_regs (
		.clk25mhz(clk25mhz),
		.rst(rst),
		.bus_slave_en(bus_slave_en),
		.ctrl_in(ctrl_in),
		.bus_in(bus_in),
		.base_addr(base_addr),
		.enable_req(enable_req)
	);

	vga_fetch_master u_fetch (
		.clk25mhz(clk25mhz),
		.rst(rst),
		.row(row),
		.col(col),
		.visible(visible),
		.frame_start(frame_start),
		.base_addr(base_addr),
		.enable_req(enable_req),
		.bus_master_ack(bus_master_ack),
		.bus_req(bus_req),
		.bus_out(bus_out),
		.buf0_we(buf0_we),
		.buf1_we(buf1_we),
		.display_on(display_on)
	);

	vga_pixel_pipe u_pipe (
		.clk25mhz(clk25mhz),
		.rst(rst),
		.bus_in(bus_in[2*`VGA_PIXEL_WIDTH-1:0]), // Only the low half carries pixels.
		.buf0_we(buf0_we),
		.buf1_we(buf1_we),
		.col(col),
		.visible(visible),
		.display_on(display_on),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

`default_nettype wire

/* sim/vga_assert.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"
`default_nettype none

module vga_assert (
	input wire logic clk25mhz,
	input wire logic rst,
	input wire logic bus_req,
	input wire logic bus_master_ack,
	input wire bus_pkg::bus_word_t bus_out,
	input wire logic hsync,
	input wire logic vsync,
	input wire vga_pkg::pixel_t rgb
);

	logic [7:0] hsync_low; // Length of the current hsync pulse.

	always_ff @(posedge clk25mhz) begin
		if (rst || hsync)
			hsync_low <= '0;
		else
			hsync_low <= hsync_low + 8'd1;
	end

	// A request holds with a stable address until it is acknowledged.
	req_hold: assert property (@(posedge clk25mhz) disable iff (rst)
		(bus_req && !bus_master_ack) |=> (bus_req && $stable(bus_out)))
		else $error("bus_req dropped or bus_out changed before ack");

	hsync_width: assert property (@(posedge clk25mhz) disable iff (rst)
		$rose(hsync) |-> (hsync_low == 8'(`VGA_H_SYNC)))
		else $error("hsync low pulse is not 96 cycles long");

	sync_blank: assert property (@(posedge clk25mhz) disable iff (rst)
		(!hsync || !vsync) |-> (rgb == '0))
		else $error("rgb is not zero during a sync pulse");

endmodule

bind vga_display vga_assert u_assert (
	.clk25mhz(clk25mhz),
	.rst(rst),
	.bus_req(bus_req),
	.bus_master_ack(bus_master_ack),
	.bus_out(bus_out),
	.hsync(hsync),
	.vsync(vsync),
	.rgb(rgb)
);

`default_nettype wire

/* sim/vga_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_tb_clock #(
	parameter real period_ns = 40.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(period_ns / 2.0) clk = ~clk; // 25 MHz pixel clock.

endmodule

`default_nettype wire

/* sim/vga_tb.sv */
`timescale 1ns/1ps
`include "vga_defines.svh"
`default_nettype none

module vga_tb;

	localparam int wait_limit = 2 * `VGA_H_TOTAL * `VGA_V_TOTAL;
	localparam int row_words = `VGA_H_VISIBLE / 2;
	localparam int pair0_col = `VGA_H_TOTAL - 4;
	localparam int last_pair_col = `VGA_H_VISIBLE - 4;

	logic clk25mhz;
	logic rst;
	logic bus_master_ack;
	logic bus_slave_en;
	bus_pkg::bus_word_t bus_in;
	bus_pkg::ctrl_t ctrl_in;
	logic bus_req;
	bus_pkg::bus_word_t bus_out;
	vga_pkg::pixel_t rgb;
	logic hsync;
	logic vsync;

	int out_row; // Raster position shown on the outputs.
	int out_col;
	int frame_count;
	bus_pkg::bus_word_t model_base;
	logic model_en;
	bus_pkg::bus_word_t frame_base; // Values latched for the frame on screen.
	logic frame_en;
	logic mem_pending;
	bus_pkg::bus_word_t mem_addr;

	vga_tb_clock u_clock (.clk(clk25mhz));

	vga_display i_dut (
		.clk25mhz(clk25mhz),
		.rst(rst),
		.bus_master_ack(bus_master_ack),
		.bus_slave_en(bus_slave_en),
		.bus_in(bus_in),
		.ctrl_in(ctrl_in),
		.bus_req(bus_req),
		.bus_out(bus_out),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync)
	);

	function automatic bus_pkg::bus_word_t mem_word(bus_pkg::bus_word_t addr);
		bus_pkg::bus_word_t h;
		h = addr * 32'h9e3779b1;
		h = h ^ (h >> 15);
		h = h * 32'h85ebca6b;
		return h ^ (h >> 13);
	endfunction

	function automatic vga_pkg::pixel_t expected_pixel(bus_pkg::bus_word_t base,
			logic enabled, int row, int col);
		bus_pkg::bus_word_t word;
		if (!enabled || row >= `VGA_V_VISIBLE || col >= `VGA_H_VISIBLE)
			return '0;
		word = mem_word(base + bus_pkg::bus_word_t'(row * row_words + col / 2));
		return (col % 2 == 1) ? word[15:8] : word[7:0]; // Even pixel in the low byte.
	endfunction

	// Counter position (row, col) carries a new request.
	function automatic logic request_slot(logic enabled, int row, int col);
		if (!enabled)
			return 1'b0;
		if (col == pair0_col)
			return (row < `VGA_V_VISIBLE - 1) || (row == `VGA_V_TOTAL - 1);
		return (row < `VGA_V_VISIBLE) && (col % 2 == 0) && (col <= last_pair_col);
	endfunction

	function automatic bus_pkg::bus_word_t expected_addr(bus_pkg::bus_word_t base,
			int row, int col);
		int next_row;
		if (col == pair0_col) begin
			next_row = (row == `VGA_V_TOTAL - 1) ? 0 : row + 1;
			return base + bus_pkg::bus_word_t'(next_row * row_words);
		end
		return base + bus_pkg::bus_word_t'(row * row_words + col / 2 + 1);
	endfunction

	task automatic fail_run(string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_pixel(string name, vga_pkg::pixel_t got, vga_pkg::pixel_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s got %h expected %h at row %0d col %0d",
				name, got, exp, out_row, out_col));
	endtask

	task automatic check_sync(string name, logic got, logic exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s got %h expected %h at row %0d col %0d",
				name, got, exp, out_row, out_col));
	endtask

	task automatic check_addr(bus_pkg::bus_word_t got, bus_pkg::bus_word_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED bus_out got %h expected %h at row %0d col %0d",
				got, exp, out_row, out_col));
	endtask

	// Outputs show the position one cycle behind the counters.
	task automatic check_cycle();
		int cnt_row;
		int cnt_col;
		logic hs_exp;
		logic vs_exp;
		cnt_row = out_row;
		cnt_col = out_col + 1;
		if (cnt_col == `VGA_H_TOTAL) begin
			cnt_col = 0;
			cnt_row = (cnt_row == `VGA_V_TOTAL - 1) ? 0 : cnt_row + 1;
		end
		check_pixel("rgb", rgb, expected_pixel(frame_base, frame_en, out_row, out_col));
		hs_exp = !((out_col >= `VGA_H_VISIBLE + `VGA_H_FRONT) &&
			(out_col < `VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC));
		vs_exp = !((out_row >= `VGA_V_VISIBLE + `VGA_V_FRONT) &&
			(out_row < `VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC));
		check_sync("hsync", hsync, hs_exp);
		check_sync("vsync", vsync, vs_exp);
		if (request_slot(frame_en, cnt_row, cnt_col)) begin
			check_sync("bus_req", bus_req, 1'b1);
			check_addr(bus_out, expected_addr(frame_base, cnt_row, cnt_col));
		end else if (!bus_master_ack) begin
			check_sync("bus_req", bus_req, 1'b0);
		end
		if (cnt_row == `VGA_V_TOTAL - 1 && cnt_col == pair0_col - 1) begin
			frame_base = model_base; // DUT latches at this column.
			frame_en = model_en;
		end
		out_row = cnt_row;
		out_col = cnt_col;
		if (out_row == 0 && out_col == 0)
			frame_count++;
	endtask

	// Memory answers one cycle after it sees a new request.
	always @(negedge clk25mhz) begin
		mem_pending = bus_req && !bus_master_ack && !rst;
		mem_addr = bus_out;
	end

	always @(posedge clk25mhz) begin
		#2;
		bus_master_ack = mem_pending;
		if (mem_pending)
			bus_in = mem_word(mem_addr);
	end

	task automatic write_reg(bus_pkg::reg_idx_t idx, bus_pkg::bus_word_t data);
		@(posedge clk25mhz);
		#2;
		bus_slave_en = 1'b1;
		ctrl_in = bus_pkg::ctrl_t'({idx, 4'b0010}); // Write bit set.
		bus_in = data;
		if (idx == bus_pkg::reg_base)
			model_base = data;
		else
			model_en = data[0];
		@(posedge clk25mhz);
		#2;
		bus_slave_en = 1'b0;
		ctrl_in = '0;
	endtask

	task automatic wait_for_pos(int row, int col);
		logic found;
		found = 1'b0;
		for (int i = 0; i < wait_limit && !found; i++) begin
			@(posedge clk25mhz);
			found = (out_row == row) && (out_col == col);
		end
		if (!found)
			fail_run($sformatf("Timed out waiting for row %0d col %0d", row, col));
	endtask

	task automatic wait_for_frame(int count);
		logic found;
		found = 1'b0;
		for (int i = 0; i < wait_limit && !found; i++) begin
			@(posedge clk25mhz);
			found = (frame_count >= count);
		end
		if (!found)
			fail_run($sformatf("Timed out waiting for frame %0d", count));
	endtask

	initial begin
		logic started;
		started = 1'b0;
		for (int i = 0; i < 100 && !started; i++) begin
			@(posedge clk25mhz);
			started = !rst;
		end
		if (!started)
			fail_run("Reset never released");
		forever begin
			@(negedge clk25mhz);
			check_cycle();
		end
	end

	initial begin
		rst = 1'b1;
		bus_master_ack = 1'b0;
		bus_slave_en = 1'b0;
		bus_in = '0;
		ctrl_in = '0;
		out_row = 0;
		out_col = 0;
		frame_count = 0;
		model_base = '0;
		model_en = 1'b0;
		frame_base = '0;
		frame_en = 1'b0;
		mem_pending = 1'b0;
		mem_addr = '0;
		void'($urandom(32'h2a18c800));
		repeat (16) @(posedge clk25mhz);
		#2;
		rst = 1'b0;

		wait_for_frame(1); // First frame runs with the display off.
		wait_for_pos(10, 700);
		write_reg(bus_pkg::reg_base, $urandom & 32'h00ff_ffff);
		write_reg(bus_pkg::reg_enable, 32'h1);
		wait_for_frame(2);
		wait_for_pos(200, 700);
		write_reg(bus_pkg::reg_base, $urandom & 32'h00ff_ffff); // Mid-frame change.
		wait_for_frame(4);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/bus_pkg.sv
hw/vga_pkg.sv
hw/vga_sync_gen.sv
hw/vga_slave_regs.sv
hw/vga_fetch_master.sv
hw/vga_pixel_pipe.sv
hw/vga_display.sv
sim/vga_assert.sv
sim/vga_tb_clock.sv
sim/vga_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module vga_tb -o vga_sim

out=$(./obj_dir/vga_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
